/* Bender.yml */
package:
  name: core_pipeline

sources:
  - include_dirs:
      - hw
    files:
      - hw/isa_pkg.sv
      - hw/ctrl_pkg.sv
      - hw/decode_unit.sv
      - hw/execute_unit.sv
      - hw/result_unit.sv
      - hw/hazard_ctrl.sv
      - hw/core_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verif/core_tb.sv

/* hw/core_cfg.svh */
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// first fetch address after reset.
`define CORE_RESET_PC 32'h0000_0000

// trace credits held by the core after reset.
`define CORE_WB_CREDITS 4

// architectural registers, x0 included.
`define CORE_NUM_REGS 32

`endif

/* hw/core_top.sv */
`include "core_cfg.svh"

module core_top import isa_pkg::*, ctrl_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  word_t     instr,
    input  word_t     dmem_rdata,
    input  logic      wb_credit,
    output word_t     pc,
    output word_t     dmem_addr,
    output word_t     dmem_wdata,
    output logic      dmem_we,
    output logic      dmem_re,
    output logic      wb_valid,
    output reg_addr_t wb_rd,
    output word_t     wb_data
);
    word_t     regs [`CORE_NUM_REGS];
    word_t     pc_d, instr_d, pc_e, rd1_e, rd2_e, imm_e;
    word_t     alu_out_m, store_data_m, pc_plus_4_m, alu_out_w, pc_plus_4_w, mem_rd_w;
    logic      valid_d, valid_e, valid_m, valid_w;
    alu_op_e   alu_ctrl_e;
    alu_src_e  alu_src_a_e, alu_src_b_e;
    res_src_e  result_src_e, result_src_m, result_src_w;
    logic      rf_we_e, mem_we_e, mem_re_e, jal_e;
    logic      rf_we_m, mem_we_m, mem_re_m, rf_we_w;
    reg_addr_t rs1_e, rs2_e, rd_e, rd_m, rd_w;

    // decode stage outputs.
    word_t     imm_dec, rd1_d, rd2_d;
    imm_src_e  imm_src_dec;
    alu_op_e   alu_ctrl_dec;
    alu_src_e  alu_src_a_dec, alu_src_b_dec;
    res_src_e  result_src_dec;
    logic      rf_we_dec, mem_we_dec, mem_re_dec, is_jal_dec;
    reg_addr_t rs1_dec, rs2_dec, rd_dec, rs1_used, rs2_used;

    word_t     alu_out_x, store_data_x, jal_target, result_w;
    fwd_sel_e  fwd_a, fwd_b;
    logic      stall_fd, flush_fd_de, wb_stall, rf_write;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= `CORE_RESET_PC;
        end else if (!wb_stall && (flush_fd_de || !stall_fd)) begin
            pc <= flush_fd_de ? jal_target : pc + 32'd4;
        end
    end

    // F/D. a flushed slot holds an all-zero word, which decodes as a no-op.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_d <= 1'b0;
            instr_d <= '0;
            pc_d    <= '0;
        end else if (!wb_stall && flush_fd_de) begin
            valid_d <= 1'b0;
            instr_d <= '0;
        end else if (!wb_stall && !stall_fd) begin
            valid_d <= 1'b1;
            instr_d <= instr;
            pc_d    <= pc;
        end
    end

    decode_unit u_decode (
        .instr      (instr_d),
        .imm        (imm_dec),
        .imm_src    (imm_src_dec),
        .alu_ctrl   (alu_ctrl_dec),
        .alu_src_a  (alu_src_a_dec),
        .alu_src_b  (alu_src_b_dec),
        .result_src (result_src_dec),
        .rf_we      (rf_we_dec),
        .mem_we     (mem_we_dec),
        .mem_re     (mem_re_dec),
        .is_jal     (is_jal_dec),
        .rs1        (rs1_dec),
        .rs2        (rs2_dec),
        .rd         (rd_dec)
    );

    // register file, x0 is never written.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `CORE_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (rf_write) begin
            regs[rd_w] <= result_w;
        end
    end

    // writeback and decode of the same register in one cycle read the new value.
    assign rd1_d = (rf_write && rd_w == rs1_dec) ? result_w : regs[rs1_dec];
    assign rd2_d = (rf_write && rd_w == rs2_dec) ? result_w : regs[rs2_dec];

    // lui and jal carry immediate bits in rs1, so they must not cause a stall.
    assign rs1_used = (imm_src_dec inside {IMM_SRC_U, IMM_SRC_J}) ? '0 : rs1_dec;
    assign rs2_used = (alu_src_b_dec == ALU_SRC_REG_2 || mem_we_dec) ? rs2_dec : '0;

    // D/E. a stall or flush inserts a bubble.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_e      <= 1'b0;
            {rf_we_e, mem_we_e, mem_re_e, jal_e} <= '0;
            {pc_e, rd1_e, rd2_e, imm_e} <= '0;
            {rs1_e, rs2_e, rd_e} <= '0;
            alu_ctrl_e   <= ALU_ADD;
            alu_src_a_e  <= ALU_SRC_REG_1;
            alu_src_b_e  <= ALU_SRC_REG_2;
            result_src_e <= RES_SRC_ALU_OUT;
        end else if (!wb_stall && (stall_fd || flush_fd_de)) begin
            valid_e <= 1'b0;
            {rf_we_e, mem_we_e, mem_re_e, jal_e} <= '0;
            rd_e    <= '0;
        end else if (!wb_stall) begin
            valid_e      <= valid_d;
            rf_we_e      <= rf_we_dec && valid_d;
            mem_we_e     <= mem_we_dec && valid_d;
            mem_re_e     <= mem_re_dec && valid_d;
            jal_e        <= is_jal_dec && valid_d;
            {pc_e, rd1_e, rd2_e, imm_e} <= {pc_d, rd1_d, rd2_d, imm_dec};
            {rs1_e, rs2_e, rd_e} <= {rs1_dec, rs2_dec, rd_dec};
            alu_ctrl_e   <= alu_ctrl_dec;
            alu_src_a_e  <= alu_src_a_dec;
            alu_src_b_e  <= alu_src_b_dec;
            result_src_e <= result_src_dec;
        end
    end

    execute_unit u_execute (
        .rd1        (rd1_e),
        .rd2        (rd2_e),
        .imm        (imm_e),
        .pc         (pc_e),
        .alu_ctrl   (alu_ctrl_e),
        .alu_src_a  (alu_src_a_e),
        .alu_src_b  (alu_src_b_e),
        .fwd_a      (fwd_a),
        .fwd_b      (fwd_b),
        .alu_out_m  (alu_out_m),
        .result_w   (result_w),
        .alu_out    (alu_out_x),
        .store_data (store_data_x),
        .jal_target (jal_target)
    );

    // E/M and M/W, both frozen by a trace stall.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            {valid_m, rf_we_m, mem_we_m, mem_re_m, valid_w, rf_we_w} <= '0;
            {alu_out_m, store_data_m, pc_plus_4_m} <= '0;
            {alu_out_w, pc_plus_4_w, mem_rd_w} <= '0;
            {rd_m, rd_w} <= '0;
            result_src_m <= RES_SRC_ALU_OUT;
            result_src_w <= RES_SRC_ALU_OUT;
        end else if (!wb_stall) begin
            {valid_m, rf_we_m, mem_we_m, mem_re_m} <= {valid_e, rf_we_e, mem_we_e, mem_re_e};
            {alu_out_m, store_data_m, pc_plus_4_m} <= {alu_out_x, store_data_x, pc_e + 32'd4};
            rd_m         <= rd_e;
            result_src_m <= result_src_e;
            {valid_w, rf_we_w, rd_w} <= {valid_m, rf_we_m, rd_m};
            {alu_out_w, pc_plus_4_w, mem_rd_w} <= {alu_out_m, pc_plus_4_m, dmem_rdata};
            result_src_w <= result_src_m;
        end
    end

    assign dmem_addr  = alu_out_m;
    assign dmem_wdata = store_data_m;
    assign dmem_we    = valid_m && mem_we_m && !wb_stall; // the store waits out the stall.
    assign dmem_re    = valid_m && mem_re_m;

    result_unit u_result (
        .clk        (clk),
        .arst_n     (arst_n),
        .result_src (result_src_w),
        .alu_out    (alu_out_w),
        .pc_plus_4  (pc_plus_4_w),
        .mem_rd     (mem_rd_w),
        .rd         (rd_w),
        .rf_we      (rf_we_w),
        .valid      (valid_w),
        .wb_credit  (wb_credit),
        .result     (result_w),
        .rf_write   (rf_write),
        .wb_stall   (wb_stall),
        .wb_valid   (wb_valid),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data)
    );

    hazard_ctrl u_hazard (
        .rs1_e       (rs1_e),
        .rs2_e       (rs2_e),
        .rs1_d       (rs1_used),
        .rs2_d       (rs2_used),
        .rd_e        (rd_e),
        .rd_m        (rd_m),
        .rd_w        (rd_w),
        .rf_we_m     (rf_we_m),
        .rf_we_w     (rf_we_w),
        .mem_re_e    (mem_re_e),
        .jal_e       (jal_e),
        .fwd_a       (fwd_a),
        .fwd_b       (fwd_b),
        .stall_fd    (stall_fd),
        .flush_fd_de (flush_fd_de)
    );

endmodule

/* hw/ctrl_pkg.sv */
package ctrl_pkg;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B // lui needs the immediate unchanged.
    } alu_op_e;

    typedef enum logic [1:0] {
        ALU_SRC_REG_1,
        ALU_SRC_REG_2,
        ALU_SRC_EXT_IMM,
        ALU_SRC_PC
    } alu_src_e;

    typedef enum logic [1:0] {
        IMM_SRC_I,
        IMM_SRC_S,
        IMM_SRC_U,
        IMM_SRC_J
    } imm_src_e;

    // 2'b11 is left unused.
    typedef enum logic [1:0] {
        RES_SRC_ALU_OUT,
        RES_SRC_PC_PLUS_4,
        RES_SRC_MEM
    } res_src_e;

    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_FROM_M,
        FWD_FROM_W
    } fwd_sel_e;

endpackage

/* hw/decode_unit.sv */
module decode_unit import isa_pkg::*, ctrl_pkg::*; (
    input  word_t     instr,
    output word_t     imm,
    output imm_src_e  imm_src,
    output alu_op_e   alu_ctrl,
    output alu_src_e  alu_src_a,
    output alu_src_e  alu_src_b,
    output res_src_e  result_src,
    output logic      rf_we,
    output logic      mem_we,
    output logic      mem_re,
    output logic      is_jal,
    output reg_addr_t rs1,
    output reg_addr_t rs2,
    output reg_addr_t rd
);
    opcode_e    opcode;
    logic [2:0] funct3;
    logic       known;

    assign opcode = opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign rd     = instr[11:7];

    always_comb begin
        // defaults describe a no-op.
        imm_src    = IMM_SRC_I;
        alu_ctrl   = ALU_ADD;
        alu_src_a  = ALU_SRC_REG_1;
        alu_src_b  = ALU_SRC_REG_2;
        result_src = RES_SRC_ALU_OUT;
        rf_we      = 1'b0;
        mem_we     = 1'b0;
        mem_re     = 1'b0;
        is_jal     = 1'b0;
        known      = 1'b1;
        case (opcode)
            OP_REG: begin
                rf_we = 1'b1;
                case (funct3)
                    F3_ADD_SUB: alu_ctrl = instr[30] ? ALU_SUB : ALU_ADD;
                    F3_SLT:     alu_ctrl = ALU_SLT;
                    F3_XOR:     alu_ctrl = ALU_XOR;
                    F3_OR:      alu_ctrl = ALU_OR;
                    F3_AND:     alu_ctrl = ALU_AND;
                    default:    rf_we = 1'b0; // shifts and sltu are not supported.
                endcase
            end
            OP_IMM: begin
                alu_src_b = ALU_SRC_EXT_IMM;
                rf_we     = (funct3 == F3_ADD_SUB); // addi only.
            end
            OP_LUI: begin
                imm_src   = IMM_SRC_U;
                alu_ctrl  = ALU_PASS_B;
                alu_src_b = ALU_SRC_EXT_IMM;
                rf_we     = 1'b1;
            end
            OP_LOAD: begin
                alu_src_b  = ALU_SRC_EXT_IMM;
                result_src = RES_SRC_MEM;
                rf_we      = (funct3 == F3_WORD);
                mem_re     = (funct3 == F3_WORD);
            end
            OP_STORE: begin
                imm_src   = IMM_SRC_S;
                alu_src_b = ALU_SRC_EXT_IMM;
                mem_we    = (funct3 == F3_WORD);
            end
            OP_JAL: begin
                imm_src    = IMM_SRC_J;
                result_src = RES_SRC_PC_PLUS_4; // link value.
                rf_we      = 1'b1;
                is_jal     = 1'b1;
            end
            default: known = 1'b0;
        endcase
    end

    always_comb begin
        case (imm_src)
            IMM_SRC_I: imm = {{20{instr[31]}}, instr[31:20]};
            IMM_SRC_S: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            IMM_SRC_U: imm = {instr[31:12], 12'b0};
            IMM_SRC_J: imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
        endcase
    end

    // every supported opcode must pick a real writeback source.
    res_src_defined: assert #0 (!known ||
        result_src inside {RES_SRC_ALU_OUT, RES_SRC_PC_PLUS_4, RES_SRC_MEM})
        else $error("decode left result_src undefined for opcode %b", instr[6:0]);

endmodule

/* hw/execute_unit.sv */
module execute_unit import isa_pkg::*, ctrl_pkg::*; (
    input  word_t    rd1,
    input  word_t    rd2,
    input  word_t    imm,
    input  word_t    pc,
    input  alu_op_e  alu_ctrl,
    input  alu_src_e alu_src_a,
    input  alu_src_e alu_src_b,
    input  fwd_sel_e fwd_a,
    input  fwd_sel_e fwd_b,
    input  word_t    alu_out_m,
    input  word_t    result_w,
    output word_t    alu_out,
    output word_t    store_data,
    output word_t    jal_target
);
    word_t src_1, src_2;
    word_t op_a, op_b;

    // pick the newest copy of a source register.
    function automatic word_t forward(fwd_sel_e sel, word_t reg_val, word_t m_val, word_t w_val);
        case (sel)
            FWD_FROM_M: return m_val;
            FWD_FROM_W: return w_val;
            default:    return reg_val;
        endcase
    endfunction

    function automatic word_t pick_src(alu_src_e sel, word_t r1, word_t r2, word_t i, word_t p);
        case (sel)
            ALU_SRC_REG_1:   return r1;
            ALU_SRC_REG_2:   return r2;
            ALU_SRC_EXT_IMM: return i;
            default:         return p;
        endcase
    endfunction

    assign src_1      = forward(fwd_a, rd1, alu_out_m, result_w);
    assign src_2      = forward(fwd_b, rd2, alu_out_m, result_w);
    assign store_data = src_2; // sw writes the forwarded rs2.

    assign op_a = pick_src(alu_src_a, src_1, src_2, imm, pc);
    assign op_b = pick_src(alu_src_b, src_1, src_2, imm, pc);

    always_comb begin
        case (alu_ctrl)
            ALU_ADD:    alu_out = op_a + op_b;
            ALU_SUB:    alu_out = op_a - op_b;
            ALU_AND:    alu_out = op_a & op_b;
            ALU_OR:     alu_out = op_a | op_b;
            ALU_XOR:    alu_out = op_a ^ op_b;
            ALU_SLT:    alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_PASS_B: alu_out = op_b;
            default:    alu_out = '0;
        endcase
    end

    assign jal_target = pc + imm;

    // the unused code 2'b11 would mean a forward from M and W at once.
    fwd_a_legal: assert #0 (fwd_a inside {FWD_NONE, FWD_FROM_M, FWD_FROM_W})
        else $error("fwd_a selects both the M and the W stage");

endmodule

/* hw/hazard_ctrl.sv */
module hazard_ctrl import isa_pkg::*, ctrl_pkg::*; (
    input  reg_addr_t rs1_e,
    input  reg_addr_t rs2_e,
    input  reg_addr_t rs1_d,
    input  reg_addr_t rs2_d,
    input  reg_addr_t rd_e,
    input  reg_addr_t rd_m,
    input  reg_addr_t rd_w,
    input  logic      rf_we_m,
    input  logic      rf_we_w,
    input  logic      mem_re_e,
    input  logic      jal_e,
    output fwd_sel_e  fwd_a,
    output fwd_sel_e  fwd_b,
    output logic      stall_fd,
    output logic      flush_fd_de
);
    // the younger result in M wins over the one in W.
    function automatic fwd_sel_e fwd_for(reg_addr_t rs, reg_addr_t m_rd, logic m_we,
                                         reg_addr_t w_rd, logic w_we);
        if (rs == '0) begin
            return FWD_NONE;
        end else if (m_we && rs == m_rd) begin
            return FWD_FROM_M;
        end else if (w_we && rs == w_rd) begin
            return FWD_FROM_W;
        end
        return FWD_NONE;
    endfunction

    assign fwd_a = fwd_for(rs1_e, rd_m, rf_we_m, rd_w, rf_we_w);
    assign fwd_b = fwd_for(rs2_e, rd_m, rf_we_m, rd_w, rf_we_w);

    // load data only exists after M, so a dependent in D waits one cycle.
    assign stall_fd = mem_re_e && (rd_e != '0) && (rd_e == rs1_d || rd_e == rs2_d);

    assign flush_fd_de = jal_e;

    stall_xor_flush: assert #0 (!(stall_fd && flush_fd_de))
        else $error("load-use stall and jal flush in the same cycle");

endmodule

/* hw/isa_pkg.sv */
package isa_pkg;

    typedef logic [31:0] word_t;     // data and instruction word.
    typedef logic [4:0]  reg_addr_t; // register index.

    // major opcodes of the supported RV32I subset.
    typedef enum logic [6:0] {
        OP_LOAD  = 7'b0000011,
        OP_IMM   = 7'b0010011,
        OP_STORE = 7'b0100011,
        OP_REG   = 7'b0110011,
        OP_LUI   = 7'b0110111,
        OP_JAL   = 7'b1101111
    } opcode_e;

    // funct3 codes for register and immediate arithmetic.
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // width code of word loads and stores.
    localparam logic [2:0] F3_WORD = 3'b010;

endpackage

/* hw/result_unit.sv */
`include "core_cfg.svh"

module result_unit import isa_pkg::*, ctrl_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  res_src_e  result_src,
    input  word_t     alu_out,
    input  word_t     pc_plus_4,
    input  word_t     mem_rd,
    input  reg_addr_t rd,
    input  logic      rf_we,
    input  logic      valid,
    input  logic      wb_credit,
    output word_t     result,
    output logic      rf_write,
    output logic      wb_stall,
    output logic      wb_valid,
    output reg_addr_t wb_rd,
    output word_t     wb_data
);
    localparam int CW = $clog2(`CORE_WB_CREDITS + 1);

    logic [CW-1:0] credits;
    logic          writes;

    always_comb begin
        case (result_src)
            RES_SRC_PC_PLUS_4: result = pc_plus_4;
            RES_SRC_MEM:       result = mem_rd;
            default:           result = alu_out;
        endcase
    end

    assign writes   = valid && rf_we && (rd != '0);
    assign wb_valid = writes && (credits != '0);
    assign wb_stall = writes && (credits == '0); // no credit, hold everything.
    assign rf_write = wb_valid;
    assign wb_rd    = rd;
    assign wb_data  = result;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            credits <= CW'(`CORE_WB_CREDITS);
        end else begin
            credits <= credits + CW'(wb_credit) - CW'(wb_valid);
        end
    end

    credits_bounded: assert property (@(posedge clk) disable iff (!arst_n)
        credits <= CW'(`CORE_WB_CREDITS))
        else $error("trace credits above %0d", `CORE_WB_CREDITS);

    valid_needs_credit: assert property (@(posedge clk) disable iff (!arst_n)
        wb_valid |-> credits != '0)
        else $error("wb_valid raised with no credit left");

endmodule

/* verif/core_tb.sv */
`include "core_cfg.svh"

module core_tb import isa_pkg::*; ();

    localparam int MEM_WORDS     = 64;
    localparam int HOLD_CYCLES   = 30;  // no credit comes back before this cycle.
    localparam int DRAIN_TIMEOUT = 600;

    logic      clk;
    logic      arst_n;
    word_t     instr = '0;
    word_t     dmem_rdata = '0;
    logic      wb_credit = 1'b0;
    word_t     pc, dmem_addr, dmem_wdata;
    logic      dmem_we, dmem_re, wb_valid;
    reg_addr_t wb_rd;
    word_t     wb_data;

    word_t     imem [MEM_WORDS];
    word_t     dmem [MEM_WORDS];
    reg_addr_t exp_rd [$];
    word_t     exp_wb_data [$];
    word_t     exp_st_addr [$];
    word_t     exp_st_data [$];
    int        credit_due [$];  // cycle at which each consumed credit is handed back.
    int        cycle = 0;
    int        outstanding = 0;
    integer    seed = 63;
    logic      running = 1'b0;

    core_top dut (
        .clk        (clk),
        .arst_n     (arst_n),
        .instr      (instr),
        .dmem_rdata (dmem_rdata),
        .wb_credit  (wb_credit),
        .pc         (pc),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_re    (dmem_re),
        .wb_valid   (wb_valid),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_idle(input word_t cur_pc, input logic cur_wb_valid,
                              input logic cur_we, input logic cur_re);
        if (cur_pc !== `CORE_RESET_PC || cur_wb_valid !== 1'b0 || cur_we !== 1'b0 ||
                cur_re !== 1'b0) begin
            abort_run($sformatf(
                "** Error at %0t: in reset expected pc %h, valid/we/re 000, got %h, %b%b%b",
                $time, `CORE_RESET_PC, cur_pc, cur_wb_valid, cur_we, cur_re));
        end
    endtask

    task automatic check_wb(input reg_addr_t rd, input word_t data);
        if (exp_rd.size() == 0) begin
            abort_run($sformatf("writeback to x%0d arrived after the last expected one", rd));
        end else if (rd !== exp_rd[0] || data !== exp_wb_data[0]) begin
            abort_run($sformatf("** Error at %0t: writeback expected x%0d = %h, got x%0d = %h",
                      $time, exp_rd[0], exp_wb_data[0], rd, data));
        end else begin
            exp_rd.delete(0);
            exp_wb_data.delete(0);
        end
    endtask

    task automatic check_store(input word_t addr, input word_t data);
        if (exp_st_addr.size() == 0) begin
            abort_run($sformatf("store to %h arrived after the last expected one", addr));
        end else if (addr !== exp_st_addr[0] || data !== exp_st_data[0]) begin
            abort_run($sformatf("** Error at %0t: store expected [%h] = %h, got [%h] = %h",
                      $time, exp_st_addr[0], exp_st_data[0], addr, data));
        end else begin
            exp_st_addr.delete(0);
            exp_st_data.delete(0);
        end
    endtask

    task automatic load_vectors();
        int               fd;
        int               n;
        logic [7:0]       tag;
        logic [31:0]      a, b;
        logic [8*160-1:0] rest;
        fd = $fopen("verif/core_vectors.txt", "r");
        if (fd == 0) begin
            abort_run("could not open verif/core_vectors.txt");
        end else begin
            while ($fscanf(fd, " %c", tag) == 1) begin
                if (tag == "#") begin
                    n = $fgets(rest, fd); // rest of a comment line.
                end else begin
                    n = $fscanf(fd, "%h %h", a, b);
                    if (n != 2) begin
                        abort_run("vector line with fewer than two fields");
                    end else if (tag == "I") begin
                        imem[a[7:2]] = b;
                    end else if (tag == "W") begin
                        exp_rd.push_back(a[4:0]);
                        exp_wb_data.push_back(b);
                    end else if (tag == "S") begin
                        exp_st_addr.push_back(a);
                        exp_st_data.push_back(b);
                    end else begin
                        abort_run("vector line with an unknown tag");
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // memories and credit return are driven on the falling edge.
    always @(negedge clk) begin
        int hit;
        instr      = imem[pc[7:2]];
        dmem_rdata = dmem_re ? dmem[dmem_addr[7:2]] : 'x; // data only comes back for a load.
        hit = -1;
        foreach (credit_due[i]) begin
            if (hit < 0 && credit_due[i] <= cycle) hit = i;
        end
        if (running && hit >= 0) begin
            wb_credit = 1'b1;
            credit_due.delete(hit);
        end else begin
            wb_credit = 1'b0;
        end
    end

    always @(posedge clk) begin
        int delay;
        if (running) begin
            if (wb_credit) outstanding--;
            if (wb_valid) begin
                outstanding++;
                check_wb(wb_rd, wb_data);
                delay = $random(seed) % 7;
                if (delay < 0) delay = -delay;
                credit_due.push_back((cycle + delay < HOLD_CYCLES) ? HOLD_CYCLES : cycle + delay);
            end
            if (outstanding > `CORE_WB_CREDITS) begin
                abort_run("more trace writebacks than credits were issued without a credit return");
            end
            if (dmem_we) begin
                check_store(dmem_addr, dmem_wdata);
                dmem[dmem_addr[7:2]] <= dmem_wdata;
            end
            cycle++;
        end
    end

    initial begin
        int waited;
        arst_n = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = '0; // all-zero word decodes as a no-op.
            dmem[i] = 32'hc0de_0000 + 32'(i * 4);
        end
        load_vectors();
        repeat (10) begin
            @(negedge clk);
            check_idle(pc, wb_valid, dmem_we, dmem_re);
        end
        arst_n  = 1'b1;
        running = 1'b1;

        waited = 0;
        while (exp_rd.size() != 0 && waited < DRAIN_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (exp_rd.size() != 0) begin
            abort_run($sformatf("timeout, %0d expected writebacks never arrived", exp_rd.size()));
        end
        waited = 0;
        while (exp_st_addr.size() != 0 && waited < DRAIN_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (exp_st_addr.size() != 0) begin
            abort_run($sformatf("timeout, %0d expected stores never arrived", exp_st_addr.size()));
        end

        // the closing jal spins, so any further writeback is an error.
        repeat (20) @(posedge clk);
        $display("Simulation passed");
        $finish;
    end

endmodule

/* verif/core_vectors.txt */
# I <byte address> <instruction> | W <rd> <value> | S <byte address> <data>, all hex.
# the core must produce the W lines in order on the trace port and the S lines as stores.
I 00000000 00500093  # addi x1, x0, 5
I 00000004 00700113  # addi x2, x0, 7
I 00000008 002081b3  # add  x3, x1, x2
I 0000000c 40308233  # sub  x4, x1, x3
I 00000010 003272b3  # and  x5, x4, x3
I 00000014 0022e333  # or   x6, x5, x2
I 00000018 003343b3  # xor  x7, x6, x3
I 0000001c 00322433  # slt  x8, x4, x3
I 00000020 123454b7  # lui  x9, 0x12345
I 00000024 67848493  # addi x9, x9, 0x678
I 00000028 00902823  # sw   x9, 16(x0)
I 0000002c 01002503  # lw   x10, 16(x0)
I 00000030 00a505b3  # add  x11, x10, x10
I 00000034 00c0076f  # jal  x14, +12
I 00000038 06300793  # addi x15, x0, 99, flushed
I 0000003c 06400813  # addi x16, x0, 100, flushed
I 00000040 00170893  # addi x17, x14, 1
I 00000044 01102a23  # sw   x17, 20(x0)
I 00000048 0000006f  # jal  x0, 0
W 01 00000005
W 02 00000007
W 03 0000000c
W 04 fffffff9
W 05 00000008
W 06 0000000f
W 07 00000003
W 08 00000001
W 09 12345000
W 09 12345678
W 0a 12345678
W 0b 2468acf0
W 0e 00000038
W 11 00000039
S 00000010 12345678
S 00000014 00000039

/* verilog.f */
+incdir+hw
hw/isa_pkg.sv
hw/ctrl_pkg.sv
hw/decode_unit.sv
hw/execute_unit.sv
hw/result_unit.sv
hw/hazard_ctrl.sv
hw/core_top.sv
verif/core_tb.sv
